// ==== vlog.f ====
ooo_pkg.sv
ooo_ifs.sv
reservation_table.sv
phys_reg_file.sv
alu_unit.sv
mul_unit.sv
wb_arbiter.sv
issue_cluster_top.sv
issue_props.sv
tb_checker.sv
tb_issue.sv

// ==== Makefile ====
TOP = tb_issue

all: run

compile:
	verilator --binary --assert -Wno-fatal -j 0 --top-module $(TOP) -f vlog.f -Mdir obj_dir -o sim_$(TOP)

run: compile
	./obj_dir/sim_$(TOP) +verilator+error+limit+1000 | tee sim.log
	@if grep -q "Verification failed" sim.log; then echo "run reported a failure"; exit 1; fi
	@grep -q "Verification passed" sim.log || (echo "run ended without a result"; exit 1)

clean:
	rm -rf obj_dir sim.log

.PHONY: all compile run clean

// ==== issue_testdata.txt ====
// kind op rob src1 src2 use_imm imm dest expected, all hex, p0 stays zero
// kind 0 alu 1 mul; op 0 add 1 sub 2 xor 3 and 4 or 5 sll
0 0 00 00 00 1 00000007 01 00000007
0 0 01 00 00 1 00000005 02 00000005
0 1 02 01 02 0 00000000 03 00000002
0 2 03 01 00 1 0000000f 04 00000008
0 4 04 03 04 0 00000000 05 0000000a
0 5 05 05 00 1 00000004 06 000000a0
0 3 06 06 00 1 00000060 07 00000020
1 0 07 01 02 0 00000000 08 00000023
1 0 08 06 06 0 00000000 09 00006400
0 0 09 08 09 0 00000000 0a 00006423
1 0 0a 09 09 0 00000000 0b 27100000
1 0 0b 0b 0a 0 00000000 0c 97300000
0 0 0c 00 00 1 12345678 0d 12345678
1 0 0d 0d 0d 0 00000000 0e 1df4d840
1 0 0e 0e 02 0 00000000 0f 95c83940
1 0 0f 0f 01 0 00000000 10 187990c0
0 0 10 10 00 1 00000001 11 187990c1
0 2 11 10 00 1 ffffffff 12 e7866f3f
0 3 12 10 03 0 00000000 13 00000000
0 4 13 10 04 0 00000000 14 187990c8
0 1 14 10 05 0 00000000 15 187990b6
0 5 15 10 00 1 00000008 16 7990c000
0 0 16 10 10 0 00000000 17 30f32180
0 0 17 17 11 0 00000000 18 496cb241

// ==== tb_issue.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk
);
    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end
endmodule

module tb_issue;
    import ooo_pkg::*;

    localparam logic [31:0] SEED = 32'hed8f_72b2;
    localparam int TIMEOUT_CYCLES = 2000;
    localparam string TESTDATA_FILE = "issue_testdata.txt";
    // words per line in the order kind op rob src1 src2 use_imm imm dest expected
    localparam int FIELDS = 9;

    logic      clk;
    logic      rst;
    logic      disp_valid    [SS];
    fu_kind_e  disp_kind     [SS];
    alu_op_e   disp_op       [SS];
    rob_id_t   disp_rob_id   [SS];
    preg_t     disp_src1_tag [SS];
    preg_t     disp_src2_tag [SS];
    logic      disp_use_imm  [SS];
    word_t     disp_imm      [SS];
    preg_t     disp_dest_tag [SS];
    logic      dispatch_stall;
    logic      cdb_valid;
    rob_id_t   cdb_rob_id;
    preg_t     cdb_dest_tag;
    word_t     cdb_value;

    logic [31:0] tdata     [FIELDS*NUM_ROB];
    logic        exp_valid [NUM_ROB];
    preg_t       exp_tag   [NUM_ROB];
    word_t       exp_value [NUM_ROB];
    int          n_instr;
    logic        started;
    int          result_count;
    int          error_count;
    logic        stall_seen;

    tb_clk_gen u_clk (.clk);

    issue_cluster_top u_dut (
        .clk, .rst,
        .disp_valid, .disp_kind, .disp_op, .disp_rob_id,
        .disp_src1_tag, .disp_src2_tag, .disp_use_imm, .disp_imm, .disp_dest_tag,
        .dispatch_stall, .cdb_valid, .cdb_rob_id, .cdb_dest_tag, .cdb_value
    );

    tb_checker u_chk (
        .clk, .rst, .started, .dispatch_stall,
        .cdb_valid, .cdb_rob_id, .cdb_dest_tag, .cdb_value,
        .exp_valid, .exp_tag, .exp_value,
        .result_count, .error_count, .stall_seen
    );

    task automatic idle_slots();
        for (int s = 0; s < SS; s++) begin
            disp_valid[s] = 1'b0;
            disp_kind[s] = FU_ALU;
            disp_op[s] = OP_ADD;
            disp_rob_id[s] = '0;
            disp_src1_tag[s] = '0;
            disp_src2_tag[s] = '0;
            disp_use_imm[s] = 1'b0;
            disp_imm[s] = '0;
            disp_dest_tag[s] = '0;
        end
    endtask

    task automatic load_testdata();
        int      base;
        rob_id_t rid;
        // kind word above 1 marks the end of the file
        for (int a = 0; a < FIELDS * NUM_ROB; a++) begin
            tdata[a] = 32'hffff_0000 | a;
        end
        for (int r = 0; r < NUM_ROB; r++) begin
            exp_valid[r] = 1'b0;
            exp_tag[r] = '0;
            exp_value[r] = '0;
        end
        $readmemh(TESTDATA_FILE, tdata);
        n_instr = 0;
        while (n_instr < NUM_ROB && tdata[FIELDS * n_instr] <= 32'd1) begin
            base = FIELDS * n_instr;
            rid = rob_id_t'(tdata[base + 2]);
            exp_valid[rid] = 1'b1;
            exp_tag[rid] = preg_t'(tdata[base + 7]);
            exp_value[rid] = tdata[base + 8];
            n_instr++;
        end
    endtask

    // one data line onto one dispatch slot
    task automatic put_slot(int s, int idx);
        int base;
        base = FIELDS * idx;
        disp_valid[s] = 1'b1;
        disp_kind[s] = fu_kind_e'(tdata[base][0]);
        disp_op[s] = alu_op_e'(tdata[base + 1][2:0]);
        disp_rob_id[s] = rob_id_t'(tdata[base + 2]);
        disp_src1_tag[s] = preg_t'(tdata[base + 3]);
        disp_src2_tag[s] = preg_t'(tdata[base + 4]);
        disp_use_imm[s] = tdata[base + 5][0];
        disp_imm[s] = tdata[base + 6];
        disp_dest_tag[s] = preg_t'(tdata[base + 7]);
    endtask

    // returns 1 ns after an edge with dispatch_stall low
    task automatic wait_stall_clear(output bit tmo);
        int cycles;
        cycles = 0;
        tmo = 1'b0;
        @(posedge clk);
        #1;
        idle_slots();
        while (dispatch_stall && !tmo) begin
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                $display("timeout: dispatch_stall stayed high for %0d cycles", cycles);
                tmo = 1'b1;
            end else begin
                @(posedge clk);
                #1;
            end
        end
    endtask

    task automatic drive_all(output bit tmo);
        int idx;
        int take;
        idx = 0;
        tmo = 1'b0;
        while (idx < n_instr && !tmo) begin
            wait_stall_clear(tmo);
            if (!tmo) begin
                // older instruction of a pair always in slot 0
                take = (n_instr - idx > 1) ? 1 + int'($urandom % 2) : 1;
                started = 1'b1;
                if (take == 2) begin
                    put_slot(0, idx);
                    put_slot(1, idx + 1);
                end else begin
                    put_slot(int'($urandom % 2), idx);
                end
                idx += take;
            end
        end
        @(posedge clk);
        #1;
        idle_slots();
    endtask

    task automatic wait_results(output bit tmo);
        int cycles;
        cycles = 0;
        tmo = 1'b0;
        while (result_count < n_instr && !tmo) begin
            @(posedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                $display("timeout: only %0d of %0d results arrived on the CDB",
                         result_count, n_instr);
                tmo = 1'b1;
            end
        end
    endtask

    initial begin
        bit timed_out;
        bit count_bad;
        void'($urandom(SEED));
        timed_out = 1'b0;
        count_bad = 1'b0;
        rst = 1'b1;
        started = 1'b0;
        idle_slots();
        load_testdata();
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        if (n_instr == 0) begin
            $display("no instructions found in %s", TESTDATA_FILE);
            count_bad = 1'b1;
        end else begin
            drive_all(timed_out);
            if (!timed_out) begin
                wait_results(timed_out);
            end
            // drain window so a late or repeated result still shows up
            if (!timed_out) begin
                repeat (20) @(posedge clk);
            end
        end
        if (result_count != n_instr) begin
            $display("expected %0d results on the CDB but saw %0d", n_instr, result_count);
            count_bad = 1'b1;
        end
        if (!stall_seen) begin
            $display("dispatch_stall never rose while the burst waited on the multiply chain");
            count_bad = 1'b1;
        end
        $display("results %0d of %0d, errors %0d, assertion failures %0d",
                 result_count, n_instr, error_count, u_dut.u_props.assert_fails);
        if (timed_out || count_bad || error_count != 0 ||
            u_dut.u_props.assert_fails != 0) begin
            $display("Verification failed");
        end else begin
            $display("Verification passed");
        end
        $finish;
    end

endmodule

// ==== tb_checker.sv ====
`timescale 1ns/1ps

module tb_checker (
    input  logic             clk,
    input  logic             rst,
    input  logic             started,
    input  logic             dispatch_stall,
    input  logic             cdb_valid,
    input  ooo_pkg::rob_id_t cdb_rob_id,
    input  ooo_pkg::preg_t   cdb_dest_tag,
    input  ooo_pkg::word_t   cdb_value,
    input  logic             exp_valid [ooo_pkg::NUM_ROB],
    input  ooo_pkg::preg_t   exp_tag   [ooo_pkg::NUM_ROB],
    input  ooo_pkg::word_t   exp_value [ooo_pkg::NUM_ROB],
    output int               result_count,
    output int               error_count,
    output logic             stall_seen
);
    import ooo_pkg::*;

    // ids already retired so repeats stand out
    logic seen [NUM_ROB];

    initial begin
        result_count = 0;
        error_count = 0;
        stall_seen = 1'b0;
        for (int r = 0; r < NUM_ROB; r++) begin
            seen[r] = 1'b0;
        end
    end

    // idle window between reset release and first dispatch
    task automatic check_quiet();
        if (cdb_valid) begin
            $display("FAILED %0t cdb_valid got %b expected 0", $time, cdb_valid);
            error_count++;
        end
        if (dispatch_stall) begin
            $display("FAILED %0t dispatch_stall got %b expected 0", $time, dispatch_stall);
            error_count++;
        end
    endtask

    // one cdb beat is one finished test
    task automatic check_result();
        logic ok;
        ok = 1'b1;
        result_count++;
        if (!exp_valid[cdb_rob_id]) begin
            $display("rob id %0d on the CDB at %0t matches no instruction in the test data",
                     cdb_rob_id, $time);
            ok = 1'b0;
        end else if (seen[cdb_rob_id]) begin
            $display("rob id %0d completed a second time at %0t", cdb_rob_id, $time);
            ok = 1'b0;
        end else begin
            seen[cdb_rob_id] = 1'b1;
            if (cdb_dest_tag !== exp_tag[cdb_rob_id]) begin
                $display("FAILED %0t cdb_dest_tag rob %0d got %0d expected %0d", $time,
                         cdb_rob_id, cdb_dest_tag, exp_tag[cdb_rob_id]);
                ok = 1'b0;
            end
            if (cdb_value !== exp_value[cdb_rob_id]) begin
                $display("FAILED %0t cdb_value rob %0d got %h expected %h", $time,
                         cdb_rob_id, cdb_value, exp_value[cdb_rob_id]);
                ok = 1'b0;
            end
        end
        if (ok) begin
            $display("rob %0d tag p%0d value %h ok", cdb_rob_id, cdb_dest_tag, cdb_value);
        end else begin
            error_count++;
        end
    endtask

    // sampled mid-cycle away from the registered cdb update
    always @(negedge clk) begin
        if (!rst && !started) begin
            check_quiet();
        end
        // burst behind the multiply chain fills a table
        if (!rst && started && dispatch_stall) begin
            stall_seen = 1'b1;
        end
        if (!rst && cdb_valid) begin
            check_result();
        end
    end

endmodule

// ==== issue_props.sv ====
`timescale 1ns/1ps

module issue_props (
    input  logic             clk,
    input  logic             rst,
    input  logic             disp_valid  [ooo_pkg::SS],
    input  ooo_pkg::rob_id_t disp_rob_id [ooo_pkg::SS],
    input  logic             dispatch_stall,
    input  logic             alu_valid,
    input  logic             alu_ready,
    input  logic             cdb_valid,
    input  ooo_pkg::rob_id_t cdb_rob_id
);
    import ooo_pkg::*;

    // read by the testbench at the end of the run
    int assert_fails;

    // rob ids dispatched and not yet seen on the cdb
    logic [NUM_ROB-1:0] pending;

    initial begin
        assert_fails = 0;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= '0;
        end else begin
            if (cdb_valid) begin
                pending[cdb_rob_id] <= 1'b0;
            end
            for (int i = 0; i < SS; i++) begin
                if (disp_valid[i] && !dispatch_stall) begin
                    pending[disp_rob_id[i]] <= 1'b1;
                end
            end
        end
    end

    // bus quiet through reset
    cdb_quiet_in_reset: assert property (@(posedge clk) rst |=> !cdb_valid)
        else begin
            $error("cdb_valid high while in reset");
            assert_fails++;
        end

    // and one more cycle after release
    cdb_quiet_after_reset: assert property (@(posedge clk) $fell(rst) |=> !cdb_valid)
        else begin
            $error("cdb_valid high in the cycle after reset");
            assert_fails++;
        end

    no_dispatch_in_stall: assert property (@(posedge clk) disable iff (rst)
        !(dispatch_stall && (disp_valid[0] || disp_valid[1])))
        else begin
            $error("dispatch presented while dispatch_stall high");
            assert_fails++;
        end

    alu_issue_handshake: assert property (@(posedge clk) disable iff (rst)
        alu_valid |-> $past(alu_ready))
        else begin
            $error("alu issue without ready in the previous cycle");
            assert_fails++;
        end

    // each broadcast must retire an outstanding id
    cdb_id_outstanding: assert property (@(posedge clk) disable iff (rst)
        cdb_valid |-> pending[cdb_rob_id])
        else begin
            $error("cdb rob_id %0d not outstanding", cdb_rob_id);
            assert_fails++;
        end

endmodule

bind issue_cluster_top issue_props u_props (
    .clk,
    .rst,
    .disp_valid,
    .disp_rob_id,
    .dispatch_stall,
    .alu_valid(alu_iss.valid),
    .alu_ready(alu_iss.ready),
    .cdb_valid,
    .cdb_rob_id
);

// ==== issue_cluster_top.sv ====
`timescale 1ns/1ps

module issue_cluster_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              disp_valid    [ooo_pkg::SS],
    input  ooo_pkg::fu_kind_e disp_kind     [ooo_pkg::SS],
    input  ooo_pkg::alu_op_e  disp_op       [ooo_pkg::SS],
    input  ooo_pkg::rob_id_t  disp_rob_id   [ooo_pkg::SS],
    input  ooo_pkg::preg_t    disp_src1_tag [ooo_pkg::SS],
    input  ooo_pkg::preg_t    disp_src2_tag [ooo_pkg::SS],
    input  logic              disp_use_imm  [ooo_pkg::SS],
    input  ooo_pkg::word_t    disp_imm      [ooo_pkg::SS],
    input  ooo_pkg::preg_t    disp_dest_tag [ooo_pkg::SS],
    output logic              dispatch_stall,
    output logic              cdb_valid,
    output ooo_pkg::rob_id_t  cdb_rob_id,
    output ooo_pkg::preg_t    cdb_dest_tag,
    output ooo_pkg::word_t    cdb_value
);
    import ooo_pkg::*;

    issue_if alu_iss ();
    issue_if mul_iss ();
    cdb_if   cdb ();

    logic               alu_full;
    logic               mul_full;
    logic               disp_take [SS];
    logic [SS-1:0][1:0] src_ready;

    logic    alu_res_valid;
    rob_id_t alu_res_rob_id;
    preg_t   alu_res_tag;
    word_t   alu_res_value;
    logic    alu_taken;
    logic    mul_res_valid;
    rob_id_t mul_res_rob_id;
    preg_t   mul_res_tag;
    word_t   mul_res_value;

    // either table short of room holds the whole pair
    assign dispatch_stall = alu_full || mul_full;

    always_comb begin
        for (int i = 0; i < SS; i++) begin
            disp_take[i] = disp_valid[i] && !dispatch_stall;
        end
    end

    reservation_table #(.TABLE_KIND(FU_ALU)) u_rt_alu (
        .clk, .rst,
        .disp_valid(disp_take), .disp_kind, .disp_op, .disp_rob_id,
        .disp_src1_tag, .disp_src2_tag, .disp_use_imm, .disp_imm, .disp_dest_tag,
        .src_ready, .cdb, .iss(alu_iss), .table_full(alu_full)
    );

    reservation_table #(.TABLE_KIND(FU_MUL)) u_rt_mul (
        .clk, .rst,
        .disp_valid(disp_take), .disp_kind, .disp_op, .disp_rob_id,
        .disp_src1_tag, .disp_src2_tag, .disp_use_imm, .disp_imm, .disp_dest_tag,
        .src_ready, .cdb, .iss(mul_iss), .table_full(mul_full)
    );

    phys_reg_file u_prf (
        .clk, .rst, .alu_iss, .mul_iss, .cdb,
        .disp_valid, .disp_src1_tag, .disp_src2_tag, .disp_dest_tag,
        .dispatch_stall, .src_ready
    );

    alu_unit u_alu (
        .clk, .rst, .iss(alu_iss),
        .res_valid(alu_res_valid), .res_rob_id(alu_res_rob_id),
        .res_tag(alu_res_tag), .res_value(alu_res_value), .res_taken(alu_taken)
    );

    mul_unit u_mul (
        .clk, .rst, .iss(mul_iss),
        .res_valid(mul_res_valid), .res_rob_id(mul_res_rob_id),
        .res_tag(mul_res_tag), .res_value(mul_res_value)
    );

    wb_arbiter u_arb (
        .clk, .rst,
        .alu_valid(alu_res_valid), .alu_rob_id(alu_res_rob_id),
        .alu_tag(alu_res_tag), .alu_value(alu_res_value),
        .mul_valid(mul_res_valid), .mul_rob_id(mul_res_rob_id),
        .mul_tag(mul_res_tag), .mul_value(mul_res_value),
        .alu_taken, .cdb
    );

    assign cdb_valid = cdb.valid;
    assign cdb_rob_id = cdb.rob_id;
    assign cdb_dest_tag = cdb.dest_tag;
    assign cdb_value = cdb.value;

endmodule

// ==== wb_arbiter.sv ====
`timescale 1ns/1ps

module wb_arbiter (
    input  logic             clk,
    input  logic             rst,
    input  logic             alu_valid,
    input  ooo_pkg::rob_id_t alu_rob_id,
    input  ooo_pkg::preg_t   alu_tag,
    input  ooo_pkg::word_t   alu_value,
    input  logic             mul_valid,
    input  ooo_pkg::rob_id_t mul_rob_id,
    input  ooo_pkg::preg_t   mul_tag,
    input  ooo_pkg::word_t   mul_value,
    output logic             alu_taken,
    cdb_if.bus_mp            cdb
);
    // multiplier pipe cannot wait, so it always wins
    assign alu_taken = alu_valid && !mul_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            cdb.valid <= 1'b0;
        end else begin
            cdb.valid <= alu_valid || mul_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (mul_valid) begin
            cdb.rob_id <= mul_rob_id;
            cdb.dest_tag <= mul_tag;
            cdb.value <= mul_value;
        end else if (alu_valid) begin
            cdb.rob_id <= alu_rob_id;
            cdb.dest_tag <= alu_tag;
            cdb.value <= alu_value;
        end
    end

endmodule

// ==== mul_unit.sv ====
`timescale 1ns/1ps

module mul_unit (
    input  logic             clk,
    input  logic             rst,
    issue_if.unit_mp         iss,
    output logic             res_valid,
    output ooo_pkg::rob_id_t res_rob_id,
    output ooo_pkg::preg_t   res_tag,
    output ooo_pkg::word_t   res_value
);
    import ooo_pkg::*;

    mul_stage_t st1;
    mul_stage_t st2;
    mul_stage_t st3;

    // stage 1: 16x16 partial products
    word_t       s1_ll;
    logic [15:0] s1_lh;
    logic [15:0] s1_hl;
    // stage 2: cross terms summed
    word_t       s2_ll;
    logic [15:0] s2_cross;

    // never stalls, always accepts
    assign iss.ready = 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            st1 <= '0;
            st2 <= '0;
            st3 <= '0;
        end else begin
            st1 <= '{valid: iss.valid, rob_id: iss.rob_id, dest_tag: iss.dest_tag};
            st2 <= st1;
            st3 <= st2;
        end
    end

    always_ff @(posedge clk) begin
        s1_ll <= iss.src1_val[15:0] * iss.src2_val[15:0];
        // only low halves of the cross terms reach the low word
        s1_lh <= iss.src1_val[15:0] * iss.src2_val[31:16];
        s1_hl <= iss.src1_val[31:16] * iss.src2_val[15:0];
        s2_ll <= s1_ll;
        s2_cross <= s1_lh + s1_hl;
        res_value <= s2_ll + {s2_cross, 16'h0000};
    end

    assign res_valid = st3.valid;
    assign res_rob_id = st3.rob_id;
    assign res_tag = st3.dest_tag;

endmodule

// ==== alu_unit.sv ====
`timescale 1ns/1ps

module alu_unit (
    input  logic             clk,
    input  logic             rst,
    issue_if.unit_mp         iss,
    output logic             res_valid,
    output ooo_pkg::rob_id_t res_rob_id,
    output ooo_pkg::preg_t   res_tag,
    output ooo_pkg::word_t   res_value,
    input  logic             res_taken
);
    import ooo_pkg::*;

    word_t opnd_b;
    word_t alu_out;

    assign opnd_b = iss.use_imm ? iss.imm : iss.src2_val;

    always_comb begin
        case (iss.op)
            OP_ADD:  alu_out = iss.src1_val + opnd_b;
            OP_SUB:  alu_out = iss.src1_val - opnd_b;
            OP_XOR:  alu_out = iss.src1_val ^ opnd_b;
            OP_AND:  alu_out = iss.src1_val & opnd_b;
            OP_OR:   alu_out = iss.src1_val | opnd_b;
            OP_SLL:  alu_out = iss.src1_val << opnd_b[4:0];
            default: alu_out = '0;
        endcase
    end

    // result slot free or leaving, and nothing already on its way in
    assign iss.ready = (!res_valid || res_taken) && !iss.valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            res_valid <= 1'b0;
        end else if (iss.valid) begin
            res_valid <= 1'b1;
        end else if (res_taken) begin
            res_valid <= 1'b0;
        end
    end

    // held until the arbiter takes it
    always_ff @(posedge clk) begin
        if (iss.valid) begin
            res_rob_id <= iss.rob_id;
            res_tag <= iss.dest_tag;
            res_value <= alu_out;
        end
    end

endmodule

// ==== phys_reg_file.sv ====
`timescale 1ns/1ps

module phys_reg_file (
    input  logic                        clk,
    input  logic                        rst,
    issue_if.prf_mp                     alu_iss,
    issue_if.prf_mp                     mul_iss,
    cdb_if.snoop_mp                     cdb,
    input  logic                        disp_valid    [ooo_pkg::SS],
    input  ooo_pkg::preg_t              disp_src1_tag [ooo_pkg::SS],
    input  ooo_pkg::preg_t              disp_src2_tag [ooo_pkg::SS],
    input  ooo_pkg::preg_t              disp_dest_tag [ooo_pkg::SS],
    input  logic                        dispatch_stall,
    output logic [ooo_pkg::SS-1:0][1:0] src_ready
);
    import ooo_pkg::*;

    word_t                regs [NUM_PREGS];
    logic [NUM_PREGS-1:0] ready_q;

    // operand reads for issue
    assign alu_iss.src1_val = regs[alu_iss.src1_tag];
    assign alu_iss.src2_val = regs[alu_iss.src2_tag];
    assign mul_iss.src1_val = regs[mul_iss.src1_tag];
    assign mul_iss.src2_val = regs[mul_iss.src2_tag];

    // readiness for the dispatched sources, with cdb bypass
    always_comb begin
        for (int i = 0; i < SS; i++) begin
            src_ready[i][0] = ready_q[disp_src1_tag[i]] ||
                              (cdb.valid && cdb.dest_tag == disp_src1_tag[i]);
            src_ready[i][1] = ready_q[disp_src2_tag[i]] ||
                              (cdb.valid && cdb.dest_tag == disp_src2_tag[i]);
            // producer in an earlier slot of the same pair
            for (int k = 0; k < i; k++) begin
                if (disp_valid[k] && disp_dest_tag[k] == disp_src1_tag[i]) begin
                    src_ready[i][0] = 1'b0;
                end
                if (disp_valid[k] && disp_dest_tag[k] == disp_src2_tag[i]) begin
                    src_ready[i][1] = 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ready_q <= '1;
            for (int r = 0; r < NUM_PREGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            if (cdb.valid) begin
                regs[cdb.dest_tag] <= cdb.value;
                ready_q[cdb.dest_tag] <= 1'b1;
            end
            // new destination goes pending, beats a cdb write
            for (int i = 0; i < SS; i++) begin
                if (disp_valid[i] && !dispatch_stall) begin
                    ready_q[disp_dest_tag[i]] <= 1'b0;
                end
            end
        end
    end

endmodule

// ==== reservation_table.sv ====
`timescale 1ns/1ps

module reservation_table #(
    parameter int                ENTRIES    = ooo_pkg::RS_ENTRIES,
    parameter ooo_pkg::fu_kind_e TABLE_KIND = ooo_pkg::FU_ALU
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         disp_valid    [ooo_pkg::SS],
    input  ooo_pkg::fu_kind_e            disp_kind     [ooo_pkg::SS],
    input  ooo_pkg::alu_op_e             disp_op       [ooo_pkg::SS],
    input  ooo_pkg::rob_id_t             disp_rob_id   [ooo_pkg::SS],
    input  ooo_pkg::preg_t               disp_src1_tag [ooo_pkg::SS],
    input  ooo_pkg::preg_t               disp_src2_tag [ooo_pkg::SS],
    input  logic                         disp_use_imm  [ooo_pkg::SS],
    input  ooo_pkg::word_t               disp_imm      [ooo_pkg::SS],
    input  ooo_pkg::preg_t               disp_dest_tag [ooo_pkg::SS],
    input  logic [ooo_pkg::SS-1:0][1:0]  src_ready,
    cdb_if.snoop_mp                      cdb,
    issue_if.table_mp                    iss,
    output logic                         table_full
);
    import ooo_pkg::*;

    // per-entry control
    logic [ENTRIES-1:0] ent_busy;
    logic [ENTRIES-1:0] ent_met1;
    logic [ENTRIES-1:0] ent_met2;

    // per-entry payload
    rob_id_t ent_rob_id   [ENTRIES];
    alu_op_e ent_op       [ENTRIES];
    preg_t   ent_src1     [ENTRIES];
    preg_t   ent_src2     [ENTRIES];
    logic    ent_use_imm  [ENTRIES];
    word_t   ent_imm      [ENTRIES];
    preg_t   ent_dest     [ENTRIES];

    logic                       alloc_en   [SS];
    logic [$clog2(ENTRIES)-1:0] alloc_idx  [SS];
    logic [ENTRIES-1:0]         alloc_mask;
    logic                       sel_found;
    logic                       sel_fire;
    logic [$clog2(ENTRIES)-1:0] sel_idx;
    logic [$clog2(ENTRIES):0]   free_cnt;

    // lowest free entry per slot, earlier slots mask theirs out
    always_comb begin
        alloc_mask = '0;
        for (int i = 0; i < SS; i++) begin
            alloc_en[i] = 1'b0;
            alloc_idx[i] = '0;
            if (disp_valid[i] && disp_kind[i] == TABLE_KIND) begin
                for (int j = ENTRIES - 1; j >= 0; j--) begin
                    if (!ent_busy[j] && !alloc_mask[j]) begin
                        alloc_en[i] = 1'b1;
                        alloc_idx[i] = j[$clog2(ENTRIES)-1:0];
                    end
                end
                if (alloc_en[i]) begin
                    alloc_mask[alloc_idx[i]] = 1'b1;
                end
            end
        end
    end

    // lowest-index entry with both operands met
    always_comb begin
        sel_found = 1'b0;
        sel_idx = '0;
        for (int j = ENTRIES - 1; j >= 0; j--) begin
            if (ent_busy[j] && ent_met1[j] && ent_met2[j]) begin
                sel_found = 1'b1;
                sel_idx = j[$clog2(ENTRIES)-1:0];
            end
        end
    end

    // only pick when the unit can take it
    assign sel_fire = sel_found && iss.ready;

    always_comb begin
        free_cnt = '0;
        for (int j = 0; j < ENTRIES; j++) begin
            if (!ent_busy[j]) begin
                free_cnt = free_cnt + 1'b1;
            end
        end
    end

    // need room for a full dispatch pair
    assign table_full = int'(free_cnt) < SS;

    always_ff @(posedge clk) begin
        if (rst) begin
            ent_busy <= '0;
        end else begin
            // wakeup from the broadcast
            for (int j = 0; j < ENTRIES; j++) begin
                if (cdb.valid && ent_src1[j] == cdb.dest_tag) begin
                    ent_met1[j] <= 1'b1;
                end
                if (cdb.valid && ent_src2[j] == cdb.dest_tag) begin
                    ent_met2[j] <= 1'b1;
                end
            end
            if (sel_fire) begin
                ent_busy[sel_idx] <= 1'b0;
            end
            // src_ready already folds in a same-cycle broadcast
            for (int i = 0; i < SS; i++) begin
                if (alloc_en[i]) begin
                    ent_busy[alloc_idx[i]] <= 1'b1;
                    ent_met1[alloc_idx[i]] <= src_ready[i][0];
                    ent_met2[alloc_idx[i]] <= src_ready[i][1] || disp_use_imm[i];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < SS; i++) begin
            if (alloc_en[i]) begin
                ent_rob_id[alloc_idx[i]] <= disp_rob_id[i];
                ent_op[alloc_idx[i]] <= disp_op[i];
                ent_src1[alloc_idx[i]] <= disp_src1_tag[i];
                ent_src2[alloc_idx[i]] <= disp_src2_tag[i];
                ent_use_imm[alloc_idx[i]] <= disp_use_imm[i];
                ent_imm[alloc_idx[i]] <= disp_imm[i];
                ent_dest[alloc_idx[i]] <= disp_dest_tag[i];
            end
        end
    end

    // issue is a one-cycle pulse
    always_ff @(posedge clk) begin
        if (rst) begin
            iss.valid <= 1'b0;
        end else begin
            iss.valid <= sel_fire;
        end
    end

    always_ff @(posedge clk) begin
        if (sel_fire) begin
            iss.rob_id <= ent_rob_id[sel_idx];
            iss.op <= ent_op[sel_idx];
            iss.src1_tag <= ent_src1[sel_idx];
            iss.src2_tag <= ent_src2[sel_idx];
            iss.use_imm <= ent_use_imm[sel_idx];
            iss.imm <= ent_imm[sel_idx];
            iss.dest_tag <= ent_dest[sel_idx];
        end
    end

endmodule

// ==== ooo_ifs.sv ====
`timescale 1ns/1ps

// table to functional unit, operands come back from the register file
interface issue_if;
    import ooo_pkg::*;

    logic    valid;
    rob_id_t rob_id;
    alu_op_e op;
    preg_t   src1_tag;
    preg_t   src2_tag;
    logic    use_imm;
    word_t   imm;
    preg_t   dest_tag;
    logic    ready;
    word_t   src1_val;
    word_t   src2_val;

    modport table_mp (
        output valid, rob_id, op, src1_tag, src2_tag, use_imm, imm, dest_tag,
        input  ready
    );
    modport unit_mp (
        input  valid, rob_id, op, use_imm, imm, dest_tag, src1_val, src2_val,
        output ready
    );
    modport prf_mp (
        input  src1_tag, src2_tag,
        output src1_val, src2_val
    );
endinterface

// one result per cycle, broadcast to everyone waiting
interface cdb_if;
    import ooo_pkg::*;

    logic    valid;
    rob_id_t rob_id;
    preg_t   dest_tag;
    word_t   value;

    modport bus_mp (output valid, rob_id, dest_tag, value);
    modport snoop_mp (input valid, rob_id, dest_tag, value);
endinterface

// ==== ooo_pkg.sv ====
package ooo_pkg;

    // dispatch width, instructions per cycle
    localparam int SS = 2;

    // default depth of each reservation table
    localparam int RS_ENTRIES = 8;

    localparam int NUM_PREGS = 32;
    localparam int NUM_ROB = 32;

    typedef logic [$clog2(NUM_PREGS)-1:0] preg_t;
    typedef logic [$clog2(NUM_ROB)-1:0] rob_id_t;
    typedef logic [31:0] word_t;

    // selects both the table and the functional unit
    typedef enum logic {
        FU_ALU = 1'b0,
        FU_MUL = 1'b1
    } fu_kind_e;

    // encodings fixed, the stimulus file uses the raw numbers
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_XOR = 3'd2,
        OP_AND = 3'd3,
        OP_OR  = 3'd4,
        OP_SLL = 3'd5
    } alu_op_e;

    // control that rides alongside the multiplier datapath
    typedef struct packed {
        logic    valid;
        rob_id_t rob_id;
        preg_t   dest_tag;
    } mul_stage_t;

endpackage
